//--- src/mipsPkg.sv
`default_nettype none

package mipsPkg;

	//////////////////////////////////////////////////
	// widths with a meaning
	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;
	typedef logic [4:0] shamtT;
	typedef logic [3:0] aluOpT;
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;

	//////////////////////////////////////////////////
	// alu operation codes
	localparam aluOpT aluAdd = 4'd0;
	localparam aluOpT aluSub = 4'd1;
	localparam aluOpT aluAnd = 4'd3;
	localparam aluOpT aluOr = 4'd4;
	localparam aluOpT aluNor = 4'd5;
	localparam aluOpT aluXor = 4'd6;
	localparam aluOpT aluSlt = 4'd9;
	localparam aluOpT aluSll = 4'd10;
	localparam aluOpT aluSrl = 4'd11;

	// primary opcodes
	localparam opcodeT opRtype = 6'b000000;
	localparam opcodeT opBeq = 6'b000100;
	localparam opcodeT opBne = 6'b000101;
	localparam opcodeT opAddi = 6'b001000;
	localparam opcodeT opSlti = 6'b001010;
	localparam opcodeT opAndi = 6'b001100;
	localparam opcodeT opOri = 6'b001101;
	localparam opcodeT opXori = 6'b001110;
	localparam opcodeT opLw = 6'b100011;
	localparam opcodeT opSw = 6'b101011;

	// r-type function field
	localparam functT fnSll = 6'b000000;
	localparam functT fnSrl = 6'b000010;
	localparam functT fnAdd = 6'b100000;
	localparam functT fnSub = 6'b100010;
	localparam functT fnAnd = 6'b100100;
	localparam functT fnOr = 6'b100101;
	localparam functT fnXor = 6'b100110;
	localparam functT fnNor = 6'b100111;
	localparam functT fnSlt = 6'b101010;

	//////////////////////////////////////////////////
	// stage items
	typedef struct packed {
		logic valid;
		wordT pc;
		wordT instr;
	} fetchT;

	typedef struct packed {
		aluOpT aluOp;
		logic regDst;
		logic aluSrc;
		logic immZeroExt;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic branch;
		logic branchNe;
		logic illegal;
	} ctrlT;

	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		wordT pc;
		wordT rsVal;
		wordT rtVal;
		wordT imm;
		shamtT shamt;
		regAddrT dest;
	} decodedT;

	typedef struct packed {
		logic valid;
		ctrlT ctrl;
		wordT aluResult;
		wordT storeData;
		regAddrT dest;
		logic branchTaken;
		wordT branchTarget;
	} execT;

	// pending register write seen by decode
	typedef struct packed {
		logic valid;
		regAddrT dest;
		wordT data;
	} fwdT;

	typedef struct packed {
		logic valid;
		logic illegal;
		logic regWrite;
		regAddrT dest;
		wordT data;
		logic branchTaken;
		wordT branchTarget;
	} retireT;

endpackage

`default_nettype wire

//--- src/mipsControl.sv
`timescale 1ns/1ps
`default_nettype none

module mipsControl (
	input mipsPkg::wordT instr,
	output mipsPkg::ctrlT ctrl
);

	mipsPkg::opcodeT opcode;
	mipsPkg::functT funct;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		// unknown words fall through as an illegal no-op
		ctrl = '0;
		ctrl.illegal = 1'b1;
		case (opcode)
			mipsPkg::opRtype: begin
				ctrl.illegal = 1'b0;
				case (funct)
					mipsPkg::fnAdd: ctrl.aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSub: ctrl.aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd: ctrl.aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr: ctrl.aluOp = mipsPkg::aluOr;
					mipsPkg::fnNor: ctrl.aluOp = mipsPkg::aluNor;
					mipsPkg::fnXor: ctrl.aluOp = mipsPkg::aluXor;
					mipsPkg::fnSlt: ctrl.aluOp = mipsPkg::aluSlt;
					mipsPkg::fnSll: ctrl.aluOp = mipsPkg::aluSll;
					mipsPkg::fnSrl: ctrl.aluOp = mipsPkg::aluSrl;
					default: ctrl.illegal = 1'b1;
				endcase
				// rd is the destination
				ctrl.regDst = !ctrl.illegal;
				ctrl.regWrite = !ctrl.illegal;
			end
			mipsPkg::opAddi: begin
				ctrl.illegal = 1'b0;
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			mipsPkg::opSlti: begin
				ctrl.illegal = 1'b0;
				ctrl.aluOp = mipsPkg::aluSlt;
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori: begin
				ctrl.illegal = 1'b0;
				ctrl.aluSrc = 1'b1;
				ctrl.immZeroExt = 1'b1;
				ctrl.regWrite = 1'b1;
				if (opcode == mipsPkg::opAndi)
					ctrl.aluOp = mipsPkg::aluAnd;
				else if (opcode == mipsPkg::opOri)
					ctrl.aluOp = mipsPkg::aluOr;
				else
					ctrl.aluOp = mipsPkg::aluXor;
			end
			mipsPkg::opLw: begin
				ctrl.illegal = 1'b0;
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			mipsPkg::opSw: begin
				ctrl.illegal = 1'b0;
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			mipsPkg::opBeq, mipsPkg::opBne: begin
				ctrl.illegal = 1'b0;
				ctrl.aluOp = mipsPkg::aluSub;
				ctrl.branch = 1'b1;
				ctrl.branchNe = (opcode == mipsPkg::opBne);
			end
			default: begin
				ctrl.illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/mipsRegFile.sv
`timescale 1ns/1ps
`default_nettype none

module mipsRegFile (
	input logic clk,
	input logic rstN,
	input mipsPkg::regAddrT rsAddr,
	input mipsPkg::regAddrT rtAddr,
	output mipsPkg::wordT rsData,
	output mipsPkg::wordT rtData,
	input logic wrEn,
	input mipsPkg::regAddrT wrAddr,
	input mipsPkg::wordT wrData
);

	mipsPkg::wordT regs [32];

	// register zero is never written, so it reads zero
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];

endmodule

`default_nettype wire

//--- src/mipsDecode.sv
`timescale 1ns/1ps
`default_nettype none

module mipsDecode (
	input logic clk,
	input logic rstN,
	input mipsPkg::fetchT fetch,
	input mipsPkg::fwdT execFwd,
	input mipsPkg::fwdT resultFwd,
	output mipsPkg::regAddrT rsAddr,
	output mipsPkg::regAddrT rtAddr,
	input mipsPkg::wordT rsData,
	input mipsPkg::wordT rtData,
	output mipsPkg::decodedT decoded
);

	mipsPkg::ctrlT ctrl;
	mipsPkg::regAddrT rdAddr;
	mipsPkg::wordT rsVal;
	mipsPkg::wordT rtVal;
	mipsPkg::wordT imm;

	// newest pending write wins, then the register file
	function automatic mipsPkg::wordT pickOperand(
		input mipsPkg::regAddrT addr,
		input mipsPkg::wordT fileData,
		input mipsPkg::fwdT fromExec,
		input mipsPkg::fwdT fromResult
	);
		logic execHit;
		logic resultHit;
		execHit = fromExec.valid && fromExec.dest == addr && addr != '0;
		resultHit = fromResult.valid && fromResult.dest == addr && addr != '0;
		if (execHit)
			return fromExec.data;
		if (resultHit)
			return fromResult.data;
		return fileData;
	endfunction

	mipsControl i_control (
		.instr(fetch.instr),
		.ctrl(ctrl)
	);

	assign rsAddr = fetch.instr[25:21];
	assign rtAddr = fetch.instr[20:16];
	assign rdAddr = fetch.instr[15:11];

	assign rsVal = pickOperand(rsAddr, rsData, execFwd, resultFwd);
	assign rtVal = pickOperand(rtAddr, rtData, execFwd, resultFwd);

	// logic immediates are zero extended
	assign imm = ctrl.immZeroExt ? {16'h0000, fetch.instr[15:0]} :
		{{16{fetch.instr[15]}}, fetch.instr[15:0]};

	always_ff @(posedge clk) begin
		decoded.pc <= fetch.pc;
		decoded.rsVal <= rsVal;
		decoded.rtVal <= rtVal;
		decoded.imm <= imm;
		decoded.shamt <= fetch.instr[10:6];
		decoded.dest <= ctrl.regDst ? rdAddr : rtAddr;
		if (!rstN) begin
			decoded.valid <= 1'b0;
			decoded.ctrl <= '0;
		end else begin
			decoded.valid <= fetch.valid;
			decoded.ctrl <= fetch.valid ? ctrl : '0;
		end
	end

endmodule

`default_nettype wire

//--- src/mipsExecute.sv
`timescale 1ns/1ps
`default_nettype none

module mipsExecute (
	input logic clk,
	input logic rstN,
	input mipsPkg::decodedT decoded,
	output mipsPkg::fwdT execFwd,
	output mipsPkg::execT executed
);

	mipsPkg::wordT opB;
	mipsPkg::wordT aluResult;
	mipsPkg::wordT target;
	logic taken;

	//////////////////////////////////////////////////
	// alu
	assign opB = decoded.ctrl.aluSrc ? decoded.imm : decoded.rtVal;

	always_comb begin
		case (decoded.ctrl.aluOp)
			mipsPkg::aluAdd: aluResult = decoded.rsVal + opB;
			mipsPkg::aluSub: aluResult = decoded.rsVal - opB;
			mipsPkg::aluAnd: aluResult = decoded.rsVal & opB;
			mipsPkg::aluOr: aluResult = decoded.rsVal | opB;
			mipsPkg::aluNor: aluResult = ~(decoded.rsVal | opB);
			mipsPkg::aluXor: aluResult = decoded.rsVal ^ opB;
			mipsPkg::aluSlt: aluResult = {31'b0, $signed(decoded.rsVal) < $signed(opB)};
			// shifts take rt and the shamt field
			mipsPkg::aluSll: aluResult = decoded.rtVal << decoded.shamt;
			mipsPkg::aluSrl: aluResult = decoded.rtVal >> decoded.shamt;
			default: aluResult = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// branch compare and target
	assign taken = decoded.valid && decoded.ctrl.branch &&
		((decoded.rsVal == decoded.rtVal) ^ decoded.ctrl.branchNe);
	assign target = decoded.pc + 32'd4 + {decoded.imm[29:0], 2'b00};

	// loads are not ready here
	assign execFwd.valid = decoded.valid && decoded.ctrl.regWrite && !decoded.ctrl.memRead;
	assign execFwd.dest = decoded.dest;
	assign execFwd.data = aluResult;

	always_ff @(posedge clk) begin
		executed.aluResult <= aluResult;
		executed.storeData <= decoded.rtVal;
		executed.dest <= decoded.dest;
		executed.branchTarget <= target;
		if (!rstN) begin
			executed.valid <= 1'b0;
			executed.ctrl <= '0;
			executed.branchTaken <= 1'b0;
		end else begin
			executed.valid <= decoded.valid;
			executed.ctrl <= decoded.ctrl;
			executed.branchTaken <= taken;
		end
	end

endmodule

`default_nettype wire

//--- src/mipsResult.sv
`timescale 1ns/1ps
`default_nettype none

module mipsResult #(
	parameter int memWords = 64
) (
	input logic clk,
	input logic rstN,
	input mipsPkg::execT executed,
	output mipsPkg::fwdT resultFwd,
	output mipsPkg::retireT retire
);

	localparam int addrBits = $clog2(memWords);

	mipsPkg::wordT mem [memWords];
	logic [addrBits-1:0] memIndex;
	mipsPkg::wordT wbData;

	// word address, wrapped into the memory depth
	assign memIndex = addrBits'({2'b00, executed.aluResult[31:2]} % memWords);

	always_ff @(posedge clk) begin
		if (executed.valid && executed.ctrl.memWrite)
			mem[memIndex] <= executed.storeData;
	end

	assign wbData = executed.ctrl.memToReg ? mem[memIndex] : executed.aluResult;

	// same values drive the register file write
	assign resultFwd.valid = executed.valid && executed.ctrl.regWrite;
	assign resultFwd.dest = executed.dest;
	assign resultFwd.data = wbData;

	always_ff @(posedge clk) begin
		retire.dest <= executed.dest;
		retire.data <= wbData;
		retire.branchTarget <= executed.branchTarget;
		if (!rstN) begin
			retire.valid <= 1'b0;
			retire.illegal <= 1'b0;
			retire.regWrite <= 1'b0;
			retire.branchTaken <= 1'b0;
		end else begin
			retire.valid <= executed.valid;
			retire.illegal <= executed.valid && executed.ctrl.illegal;
			retire.regWrite <= resultFwd.valid;
			retire.branchTaken <= executed.valid && executed.branchTaken;
		end
	end

endmodule

`default_nettype wire

//--- src/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
	parameter int memWords = 64
) (
	input logic clk,
	input logic rstN,
	input mipsPkg::fetchT fetch,
	output mipsPkg::retireT retire
);

	mipsPkg::decodedT decoded;
	mipsPkg::execT executed;
	mipsPkg::fwdT execFwd;
	mipsPkg::fwdT resultFwd;
	mipsPkg::regAddrT rsAddr;
	mipsPkg::regAddrT rtAddr;
	mipsPkg::wordT rsData;
	mipsPkg::wordT rtData;

	//////////////////////////////////////////////////
	// decode, execute, result
	mipsDecode i_decode (
		.clk(clk),
		.rstN(rstN),
		.fetch(fetch),
		.execFwd(execFwd),
		.resultFwd(resultFwd),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rsData(rsData),
		.rtData(rtData),
		.decoded(decoded)
	);

	mipsExecute i_execute (
		.clk(clk),
		.rstN(rstN),
		.decoded(decoded),
		.execFwd(execFwd),
		.executed(executed)
	);

	mipsResult #(
		.memWords(memWords)
	) i_result (
		.clk(clk),
		.rstN(rstN),
		.executed(executed),
		.resultFwd(resultFwd),
		.retire(retire)
	);

	// write port fed from the result stage
	mipsRegFile i_regFile (
		.clk(clk),
		.rstN(rstN),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rsData(rsData),
		.rtData(rtData),
		.wrEn(resultFwd.valid),
		.wrAddr(resultFwd.dest),
		.wrData(resultFwd.data)
	);

endmodule

`default_nettype wire

//--- tb/mipsCore_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreAssertions (
	input logic clk,
	input logic rstN,
	input mipsPkg::fetchT fetch,
	input mipsPkg::retireT retire,
	input mipsPkg::fwdT resultFwd,
	input mipsPkg::execT executed
);

	int failures = 0;

	//////////////////////////////////////////////////
	// pipeline latency
	assert property (@(posedge clk) disable iff (!rstN)
		fetch.valid |-> ##3 retire.valid)
	else begin
		failures++;
		$error("accepted instruction did not retire three cycles later");
	end

	// no retire without a fetch three cycles back
	assert property (@(posedge clk) disable iff (!rstN)
		retire.valid |-> $past(fetch.valid, 3))
	else begin
		failures++;
		$error("retire pulse without a matching fetch");
	end

	//////////////////////////////////////////////////
	// reset state
	assert property (@(posedge clk) !rstN |=>
		!retire.valid && !resultFwd.valid && !executed.ctrl.memWrite)
	else begin
		failures++;
		$error("pipeline not idle after a reset cycle");
	end

	assert property (@(posedge clk) $rose(rstN) |-> !retire.valid ##1 !retire.valid)
	else begin
		failures++;
		$error("retire valid right after reset release");
	end

endmodule

bind mipsCore mipsCoreAssertions i_assertions (
	.clk(clk),
	.rstN(rstN),
	.fetch(fetch),
	.retire(retire),
	.resultFwd(resultFwd),
	.executed(executed)
);

`default_nettype wire

//--- tb/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb #(
	parameter int seedValue = 32'h5816_39dc
);

	localparam int period = 100;
	localparam int memWords = 64;
	localparam int numInit = 7;
	localparam int numRandom = 300;
	// at most one idle cycle in front of each random instruction, plus reset
	localparam int cycleLimit = numInit + 2 * numRandom + 2 + 20;

	localparam mipsPkg::functT functs [9] = '{mipsPkg::fnAdd, mipsPkg::fnSub,
		mipsPkg::fnAnd, mipsPkg::fnOr, mipsPkg::fnNor, mipsPkg::fnXor,
		mipsPkg::fnSlt, mipsPkg::fnSll, mipsPkg::fnSrl};
	localparam mipsPkg::opcodeT iOps [5] = '{mipsPkg::opAddi, mipsPkg::opSlti,
		mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori};

	logic clk;
	logic rstN;
	mipsPkg::fetchT fetch;
	mipsPkg::retireT retire;

	int seed;
	mipsPkg::wordT pc;
	mipsPkg::wordT regs [8];
	mipsPkg::wordT mem [memWords];
	int storedWords [$];
	mipsPkg::retireT expQ [$];
	logic branchQ [$];
	logic loadPending;
	mipsPkg::regAddrT loadDest;
	mipsPkg::wordT loadData;

	mipsCore #(
		.memWords(memWords)
	) i_dut (
		.clk(clk),
		.rstN(rstN),
		.fetch(fetch),
		.retire(retire)
	);

	always #(period / 2) clk = ~clk;

	task automatic stopRun(input string line);
		$display("%s", line);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped");
	endtask

	//////////////////////////////////////////////////
	// reference model in program order

	// a load lands only after the instruction behind it has read
	task automatic applyLoad();
		if (loadPending && loadDest != '0)
			regs[loadDest[2:0]] = loadData;
		loadPending = 1'b0;
	endtask

	task automatic modelIssue(input mipsPkg::wordT instr);
		mipsPkg::retireT want;
		mipsPkg::wordT a;
		mipsPkg::wordT b;
		mipsPkg::wordT immS;
		mipsPkg::wordT immZ;
		logic isBranch;
		logic isLoad;
		int idx;
		a = regs[instr[23:21]];
		b = regs[instr[18:16]];
		immS = {{16{instr[15]}}, instr[15:0]};
		immZ = {16'h0000, instr[15:0]};
		want = '0;
		want.valid = 1'b1;
		want.regWrite = 1'b1;
		want.dest = instr[20:16];
		isBranch = 1'b0;
		isLoad = 1'b0;
		idx = int'((a + immS) >> 2) % memWords;
		case (instr[31:26])
			mipsPkg::opRtype: begin
				want.dest = instr[15:11];
				case (instr[5:0])
					mipsPkg::fnAdd: want.data = a + b;
					mipsPkg::fnSub: want.data = a - b;
					mipsPkg::fnAnd: want.data = a & b;
					mipsPkg::fnOr: want.data = a | b;
					mipsPkg::fnNor: want.data = ~(a | b);
					mipsPkg::fnXor: want.data = a ^ b;
					mipsPkg::fnSlt: want.data = {31'b0, $signed(a) < $signed(b)};
					mipsPkg::fnSll: want.data = b << instr[10:6];
					mipsPkg::fnSrl: want.data = b >> instr[10:6];
					default: want.illegal = 1'b1;
				endcase
			end
			mipsPkg::opAddi: want.data = a + immS;
			mipsPkg::opSlti: want.data = {31'b0, $signed(a) < $signed(immS)};
			mipsPkg::opAndi: want.data = a & immZ;
			mipsPkg::opOri: want.data = a | immZ;
			mipsPkg::opXori: want.data = a ^ immZ;
			mipsPkg::opLw: begin
				isLoad = 1'b1;
				want.data = mem[idx];
			end
			mipsPkg::opSw: begin
				want.regWrite = 1'b0;
				mem[idx] = b;
			end
			mipsPkg::opBeq, mipsPkg::opBne: begin
				want.regWrite = 1'b0;
				isBranch = 1'b1;
				want.branchTaken = (a == b) ^ instr[26];
				want.branchTarget = pc + 32'd4 + (immS << 2);
			end
			default: want.illegal = 1'b1;
		endcase
		if (want.illegal)
			want.regWrite = 1'b0;
		applyLoad();
		loadPending = isLoad;
		loadDest = want.dest;
		loadData = want.data;
		if (want.regWrite && !isLoad && want.dest != '0)
			regs[want.dest[2:0]] = want.data;
		pc = want.branchTaken ? want.branchTarget : pc + 32'd4;
		expQ.push_back(want);
		branchQ.push_back(isBranch);
	endtask

	//////////////////////////////////////////////////
	// stimulus

	// registers 0 to 7 only and memory addressed off register zero
	task automatic pickInstr(output mipsPkg::wordT instr);
		int kind;
		int word;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		kind = $unsigned($random(seed)) % 40;
		rs = 5'($unsigned($random(seed)) % 8);
		rt = 5'($unsigned($random(seed)) % 8);
		rd = 5'($unsigned($random(seed)) % 8);
		shamt = 5'($random(seed));
		// no load before something was stored
		if (kind >= 32 && kind < 36 && storedWords.size() == 0)
			kind = 28;
		if (kind < 18) begin
			instr = {mipsPkg::opRtype, rs, rt, rd, shamt, functs[kind % 9]};
		end else if (kind < 28) begin
			instr = {iOps[kind % 5], rs, rt, 16'($random(seed))};
		end else if (kind < 32) begin
			word = $unsigned($random(seed)) % memWords;
			storedWords.push_back(word);
			instr = {mipsPkg::opSw, 5'd0, rt, 16'(word * 4)};
		end else if (kind < 36) begin
			word = storedWords[$unsigned($random(seed)) % storedWords.size()];
			instr = {mipsPkg::opLw, 5'd0, rt, 16'(word * 4)};
		end else if (kind < 39) begin
			instr = {kind[0] ? mipsPkg::opBne : mipsPkg::opBeq, rs, rt, 16'($random(seed))};
		end else if ($random(seed) & 1) begin
			// jump opcode
			instr = {6'h02, 26'($random(seed))};
		end else begin
			// jr function code
			instr = {mipsPkg::opRtype, rs, rt, rd, shamt, 6'h08};
		end
	endtask

	task automatic issue(input mipsPkg::wordT instr);
		@(posedge clk);
		fetch.valid <= 1'b1;
		fetch.pc <= pc;
		fetch.instr <= instr;
		modelIssue(instr);
	endtask

	initial begin
		mipsPkg::wordT instr;
		$timeformat(-9, 0, " ns", 0);
		seed = seedValue;
		clk = 1'b0;
		rstN = 1'b0;
		fetch = '0;
		pc = 32'h0000_0400;
		loadPending = 1'b0;
		loadDest = '0;
		loadData = '0;
		for (int r = 0; r < 8; r++)
			regs[r] = '0;
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		for (int i = 1; i <= numInit; i++)
			issue({mipsPkg::opAddi, 5'd0, 5'(i), 16'(i * 16'h2345)});
		for (int n = 0; n < numRandom; n++) begin
			if ($unsigned($random(seed)) % 6 == 0) begin
				@(posedge clk);
				fetch.valid <= 1'b0;
				applyLoad();
			end
			pickInstr(instr);
			issue(instr);
		end
		@(posedge clk);
		fetch.valid <= 1'b0;
		while (expQ.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
		if (i_dut.i_assertions.failures == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			stopRun("bound timing assertions reported failures");
		end
	end

	//////////////////////////////////////////////////
	// retire checks and watchdog

	always @(posedge clk) begin
		mipsPkg::retireT want;
		logic isBranch;
		if (retire.valid) begin
			if (expQ.size() == 0) begin
				stopRun("retire report arrived with no instruction outstanding");
			end else begin
				want = expQ.pop_front();
				isBranch = branchQ.pop_front();
				assert (retire.illegal == want.illegal && retire.regWrite == want.regWrite &&
					retire.branchTaken == want.branchTaken)
				else stopRun($sformatf("mismatch at %0t: flags ill/wr/tk %b%b%b, want %b%b%b",
					$time, retire.illegal, retire.regWrite, retire.branchTaken,
					want.illegal, want.regWrite, want.branchTaken));
				assert (!want.regWrite || (retire.dest == want.dest && retire.data == want.data))
				else stopRun($sformatf("mismatch at %0t: r%0d=%h, want r%0d=%h",
					$time, retire.dest, retire.data, want.dest, want.data));
				assert (!isBranch || retire.branchTarget == want.branchTarget)
				else stopRun($sformatf("mismatch at %0t: target %h, want %h",
					$time, retire.branchTarget, want.branchTarget));
			end
		end
	end

	// bound timing checks count their failures
	always @(posedge clk) begin
		if (i_dut.i_assertions.failures != 0)
			stopRun("a bound timing assertion failed");
	end

	initial begin
		#(cycleLimit * period);
		stopRun($sformatf("timeout: instructions still outstanding after %0d cycles",
			cycleLimit));
	end

endmodule

`default_nettype wire

//--- src.f
src/mipsPkg.sv
src/mipsControl.sv
src/mipsRegFile.sv
src/mipsDecode.sv
src/mipsExecute.sv
src/mipsResult.sv
src/mipsCore.sv
tb/mipsCore_assertions.sv
tb/mipsCoreTb.sv

//--- Makefile
# Verilator build and run of the MIPS core testbench

TOP ?= mipsCoreTb
# 32'h5816_39dc in decimal
SEED ?= 1477851612
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GseedValue=$(SEED) -f src.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
